/* compile.f */
rtl/cnn_pkg.sv
rtl/fm_write_if.sv
rtl/fm_tile_loader.sv
rtl/fm_tile_ram.sv
rtl/max_pool_engine.sv
rtl/cnn_layer_top.sv
test/cnn_layer_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the cnn layer testbench with verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module cnn_layer_tb -f compile.f -o cnn_layer_sim \
    && ./obj_dir/cnn_layer_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; }
grep -q "NO ERRORS" sim.log || { echo "simulation did not finish"; exit 1; }
echo "simulation passed"

/* test/cnn_layer_tb.sv */
`timescale 1ns/1ps

module cnn_layer_tb import cnn_pkg::*; ();

    logic                       clk = 1'b0;
    logic                       arst_n;
    layer_type_e                layer_type;
    logic [FM_SIZE_WIDTH-1:0]   fm_size;
    logic [DEPTH_WIDTH-1:0]     fm_depth;
    logic                       fm_write;
    logic [TILE_ADDR_WIDTH-1:0] write_fm_data_addr;
    logic [TILE_WIDTH-1:0]      init_fm_data;
    logic                       init_fm_data_done;
    logic                       out_ack;
    logic                       out_req;
    logic [DATA_WIDTH-1:0]      out_data;
    logic [TILE_ADDR_WIDTH-1:0] out_index;
    logic                       init_fm_ram_ready;
    logic                       layer_ready;

    integer                     seed = 40;
    logic [TILE_WIDTH-1:0]      tiles [TILE_COUNT_MAX];  // tb copy of the loaded map
    int                         out_count = 0;           // outputs acknowledged so far
    int                         expected_total = 0;      // outputs due in this pool layer
    logic                       prev_req = 1'b0;
    logic [DATA_WIDTH-1:0]      prev_data;
    logic [TILE_ADDR_WIDTH-1:0] prev_index;

    always #10 clk = ~clk;   // 20 ns period

    cnn_layer_top uut (.*);

    task automatic abort(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            abort($sformatf("** Error at %0t ns: %s expected %0h, got %0h",
                            $time, name, expected, actual));
        end
    endtask

    // finite float16 on a signed line, +0 and -0 both land on 0
    function automatic int order_key(input logic [DATA_WIDTH-1:0] v);
        return v[DATA_WIDTH-1] ? -int'(v[DATA_WIDTH-2:0]) : int'(v[DATA_WIDTH-2:0]);
    endfunction

    function automatic logic [DATA_WIDTH-1:0] pool_max(input logic [TILE_WIDTH-1:0] tile);
        logic [DATA_WIDTH-1:0] best;
        logic [DATA_WIDTH-1:0] lane;
        best = tile[DATA_WIDTH-1:0];   // lane 0 at lsb
        for (int i = 1; i < PARA_X * PARA_Y; i++) begin
            lane = tile[i*DATA_WIDTH +: DATA_WIDTH];
            if (order_key(lane) > order_key(best)) best = lane;   // strict, lower lane keeps ties
        end
        return best;
    endfunction

    task automatic fill_random(input int count);
        logic [DATA_WIDTH-1:0] v;
        for (int t = 0; t < count; t++) begin
            for (int i = 0; i < PARA_X * PARA_Y; i++) begin
                v[15]    = 1'($random(seed));
                v[14:10] = 5'({$random(seed)} % 31);   // exponent 31 would be inf or nan
                v[9:0]   = 10'($random(seed));
                tiles[t][i*DATA_WIDTH +: DATA_WIDTH] = v;
            end
        end
    endtask

    task automatic write_tile(input int addr, input logic [TILE_WIDTH-1:0] data);
        @(posedge clk);
        fm_write           <= 1'b1;
        write_fm_data_addr <= TILE_ADDR_WIDTH'(addr);
        init_fm_data       <= data;
    endtask

    task automatic load_map(input int size, input int depth, input int count);
        int order [TILE_COUNT_MAX];
        int j;
        int tmp;
        int waited;
        for (int i = 0; i < count; i++) order[i] = i;
        for (int i = count - 1; i > 0; i--) begin   // shuffled write order
            j        = {$random(seed)} % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        @(posedge clk);
        layer_type <= LAYER_INIT;
        fm_size    <= FM_SIZE_WIDTH'(size);
        fm_depth   <= DEPTH_WIDTH'(depth);
        for (int i = 0; i < count; i++) begin
            write_tile(order[i], tiles[order[i]]);
            if (i == 1) begin   // first write already sampled, ready must be gone
                @(negedge clk);
                check("init_fm_ram_ready", 0, init_fm_ram_ready);
            end
        end
        @(posedge clk);
        fm_write          <= 1'b0;
        init_fm_data_done <= 1'b1;
        waited = 0;
        while (!init_fm_ram_ready) begin
            @(negedge clk);
            waited++;
            if (waited > 20) abort("init_fm_ram_ready did not rise after init_fm_data_done");
        end
        @(posedge clk);
        init_fm_data_done <= 1'b0;
    endtask

    task automatic run_pool(input int count);
        int waited;
        @(posedge clk);
        out_count      = 0;
        expected_total = count;
        layer_type    <= LAYER_POOL;
        waited = 0;
        while (!layer_ready) begin
            @(negedge clk);
            waited++;
            if (waited > count * 40 + 50) abort("layer_ready did not rise in the pool layer");
        end
        check("output count", count, out_count);
    endtask

    task automatic conv_window();
        int waited;
        @(posedge clk);
        layer_type <= LAYER_CONV;
        waited = 0;
        while (layer_ready) begin
            @(negedge clk);
            waited++;
            if (waited > 10) abort("layer_ready did not fall after leaving the pool layer");
        end
        repeat (200) begin   // conv has no datapath here, stays silent
            @(negedge clk);
            check("out_req", 0, out_req);
            check("layer_ready", 0, layer_ready);
        end
    endtask

    // ack side of the output port, checks each result against the reference
    initial begin : ack_responder
        int delay;
        int waited;
        out_ack = 1'b0;
        forever begin
            @(negedge clk);
            if (arst_n && out_req && !out_ack) begin
                if (out_count >= expected_total) abort("out_req rose with no tile left to pool");
                check("out_index", out_count, out_index);
                check("out_data", pool_max(tiles[out_count]), out_data);
                delay = {$random(seed)} % 6;
                repeat (delay) @(negedge clk);
                @(posedge clk);
                out_ack <= 1'b1;
                waited = 0;
                while (out_req) begin
                    @(negedge clk);
                    waited++;
                    if (waited > 20) abort("out_req stayed high after out_ack");
                end
                delay = {$random(seed)} % 6;   // ack lingers after req falls
                repeat (delay) @(negedge clk);
                @(posedge clk);
                out_ack <= 1'b0;
                out_count++;
            end
        end
    end

    // handshake rules seen from outside
    always @(negedge clk) begin : handshake_monitor
        if (arst_n) begin
            if (out_req && !prev_req && out_ack) abort("out_req rose while out_ack was still high");
            if (prev_req && !out_req && !out_ack) abort("out_req fell before out_ack was raised");
            if (out_req && prev_req) begin   // held until the engine sees ack
                check("out_data", prev_data, out_data);
                check("out_index", prev_index, out_index);
            end
            if (layer_ready && out_count != expected_total) begin
                abort("layer_ready rose before all outputs were acknowledged");
            end
        end
        prev_req   = out_req;
        prev_data  = out_data;
        prev_index = out_index;
    end

    initial begin : stimulus
        arst_n             = 1'b0;
        layer_type         = LAYER_INIT;
        fm_size            = '0;
        fm_depth           = '0;
        fm_write           = 1'b0;
        write_fm_data_addr = '0;
        init_fm_data       = '0;
        init_fm_data_done  = 1'b0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check("init_fm_ram_ready", 0, init_fm_ram_ready);
        check("layer_ready", 0, layer_ready);
        check("out_req", 0, out_req);

        // map 1, 6x6 by 2 slices, first three tiles hand made, lane 8 first
        fill_random(8);
        tiles[0] = {16'hC000, 16'hBC00, 16'hB800, 16'hC400, 16'h8400,
                    16'hB400, 16'hBE00, 16'hC200, 16'hB900};   // all negative
        tiles[1] = {16'hBC00, 16'h0000, 16'hC000, 16'hB800, 16'h0000,
                    16'hC400, 16'hB400, 16'hBE00, 16'h8000};   // -0 in lane 0 ties +0
        tiles[2] = {16'h4500, 16'h3C00, 16'h4500, 16'hC500, 16'h4500,
                    16'h0000, 16'h4500, 16'h4400, 16'h4500};   // repeated positive max
        check("pool_max tile 0", 16'h8400, pool_max(tiles[0]));
        check("pool_max tile 1", 16'h8000, pool_max(tiles[1]));
        check("pool_max tile 2", 16'h4500, pool_max(tiles[2]));
        load_map(6, 2, 8);
        run_pool(8);
        conv_window();

        // map 2 fills the whole buffer
        fill_random(32);
        load_map(12, 2, 32);
        @(posedge clk);
        layer_type <= LAYER_CONV;
        write_tile(5, ~tiles[5]);   // outside init, loader drops it
        @(posedge clk);
        fm_write <= 1'b0;
        @(negedge clk);
        check("init_fm_ram_ready", 1, init_fm_ram_ready);
        run_pool(32);

        $display("NO ERRORS");
        $finish;
    end

endmodule

/* rtl/cnn_layer_top.sv */
`timescale 1ns/1ps

module cnn_layer_top import cnn_pkg::*; (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic [1:0]                 layer_type,        // 0 init, 1 conv, 2 pool, 3 fc
    input  logic [FM_SIZE_WIDTH-1:0]   fm_size,
    input  logic [DEPTH_WIDTH-1:0]     fm_depth,
    input  logic                       fm_write,
    input  logic [TILE_ADDR_WIDTH-1:0] write_fm_data_addr,
    input  logic [TILE_WIDTH-1:0]      init_fm_data,
    input  logic                       init_fm_data_done,
    input  logic                       out_ack,
    output logic                       out_req,
    output logic [DATA_WIDTH-1:0]      out_data,
    output logic [TILE_ADDR_WIDTH-1:0] out_index,
    output logic                       init_fm_ram_ready,
    output logic                       layer_ready
);

    layer_type_e                layer_sel;
    logic                       rd_en;
    logic [TILE_ADDR_WIDTH-1:0] rd_addr;
    logic [TILE_WIDTH-1:0]      rd_data;

    assign layer_sel = layer_type_e'(layer_type);

    fm_write_if fm_wr ();   // loader to buffer

    fm_tile_loader u_loader (
        .clk                (clk),
        .arst_n             (arst_n),
        .layer_type         (layer_sel),
        .fm_write           (fm_write),
        .write_fm_data_addr (write_fm_data_addr),
        .init_fm_data       (init_fm_data),
        .init_fm_data_done  (init_fm_data_done),
        .wr                 (fm_wr.loader),
        .init_fm_ram_ready  (init_fm_ram_ready)
    );

    fm_tile_ram u_ram (
        .clk     (clk),
        .wr      (fm_wr.ram),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    max_pool_engine u_pool (
        .clk         (clk),
        .arst_n      (arst_n),
        .layer_type  (layer_sel),
        .fm_size     (fm_size),
        .fm_depth    (fm_depth),
        .fill_ready  (fm_wr.fill_done),   // start gate from the loader
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .out_req     (out_req),
        .out_ack     (out_ack),
        .out_data    (out_data),
        .out_index   (out_index),
        .layer_ready (layer_ready)
    );

endmodule

/* rtl/max_pool_engine.sv */
`timescale 1ns/1ps

module max_pool_engine import cnn_pkg::*; (
    input  logic                       clk,
    input  logic                       arst_n,
    input  layer_type_e                layer_type,
    input  logic [FM_SIZE_WIDTH-1:0]   fm_size,
    input  logic [DEPTH_WIDTH-1:0]     fm_depth,
    input  logic                       fill_ready,   // map fully loaded
    output logic                       rd_en,
    output logic [TILE_ADDR_WIDTH-1:0] rd_addr,
    input  logic [TILE_WIDTH-1:0]      rd_data,
    output logic                       out_req,
    input  logic                       out_ack,
    output logic [DATA_WIDTH-1:0]      out_data,
    output logic [TILE_ADDR_WIDTH-1:0] out_index,
    output logic                       layer_ready
);

    pool_state_e                state;
    pool_state_e                state_nxt;
    logic [2:0]                 tiles_per_row;  // fm_size / 3
    logic [TILE_ADDR_WIDTH:0]   tile_total;     // up to 32, one extra bit
    logic [TILE_ADDR_WIDTH:0]   rd_ptr;         // next tile to read
    logic                       more;           // tiles left to read
    logic                       pend;           // rd_data holds a tile not yet reduced
    logic [DATA_WIDTH-1:0]      tile_max;

    // a strictly beats b, sign-magnitude compare, finite values only
    function automatic logic f16_beats(input logic [DATA_WIDTH-1:0] a,
                                       input logic [DATA_WIDTH-1:0] b);
        logic [DATA_WIDTH-2:0] mag_a;
        logic [DATA_WIDTH-2:0] mag_b;
        mag_a = a[DATA_WIDTH-2:0];
        mag_b = b[DATA_WIDTH-2:0];
        if (mag_a == '0 && mag_b == '0) return 1'b0;          // +0 equals -0
        if (a[DATA_WIDTH-1] != b[DATA_WIDTH-1]) return !a[DATA_WIDTH-1];
        if (!a[DATA_WIDTH-1]) return mag_a > mag_b;           // both positive
        return mag_a < mag_b;                                 // both negative
    endfunction

    // divide by 3 through a lookup, only legal sizes map
    always_comb begin
        case (fm_size)
            4'd3:    tiles_per_row = 3'd1;
            4'd6:    tiles_per_row = 3'd2;
            4'd9:    tiles_per_row = 3'd3;
            4'd12:   tiles_per_row = 3'd4;
            default: tiles_per_row = 3'd0;   // nothing to pool
        endcase
        tile_total = (TILE_ADDR_WIDTH+1)'(fm_depth) * (TILE_ADDR_WIDTH+1)'(tiles_per_row)
                   * (TILE_ADDR_WIDTH+1)'(tiles_per_row);
    end

    assign more = rd_ptr < tile_total;

    // nine-lane reduce, strict compare keeps the lower lane on a tie
    always_comb begin
        tile_max = rd_data[DATA_WIDTH-1:0];
        for (int i = 1; i < PARA_X * PARA_Y; i++) begin
            if (f16_beats(rd_data[i*DATA_WIDTH +: DATA_WIDTH], tile_max)) begin
                tile_max = rd_data[i*DATA_WIDTH +: DATA_WIDTH];
            end
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            PL_IDLE: begin
                if (layer_type == LAYER_POOL && fill_ready) begin
                    state_nxt = (tile_total == '0) ? PL_DONE : PL_FETCH;
                end
            end
            PL_FETCH:   state_nxt = PL_REDUCE;
            PL_REDUCE:  state_nxt = PL_REQ;
            PL_REQ:     if (out_ack) state_nxt = PL_RELEASE;
            PL_RELEASE: begin
                if (!out_ack) begin   // four-phase closed
                    if (pend) state_nxt = PL_REDUCE;      // prefetched tile waiting
                    else state_nxt = PL_DONE;             // no tile left to read
                end
            end
            PL_DONE:    if (layer_type != LAYER_POOL) state_nxt = PL_IDLE;
            default:    state_nxt = PL_IDLE;
        endcase
    end

    // read in FETCH, or prefetch once while the handshake is open
    assign rd_en   = (state == PL_FETCH) || (state == PL_REQ && more && !pend);
    assign rd_addr = rd_ptr[TILE_ADDR_WIDTH-1:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= PL_IDLE;
            rd_ptr <= '0;
            pend   <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == PL_IDLE) rd_ptr <= '0;
            else if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            if (rd_en) pend <= 1'b1;
            else if (state == PL_REDUCE) pend <= 1'b0;
        end
    end

    // result registers, stable from REQ until the next REDUCE
    always_ff @(posedge clk) begin
        if (state == PL_REDUCE) begin
            out_data  <= tile_max;
            out_index <= rd_addr - 1'b1;   // tile read just before
        end
    end

    assign out_req     = (state == PL_REQ);
    assign layer_ready = (state == PL_DONE);

endmodule

/* rtl/fm_tile_ram.sv */
`timescale 1ns/1ps

module fm_tile_ram import cnn_pkg::*; (
    input  logic                       clk,
    fm_write_if.ram                    wr,
    input  logic                       rd_en,
    input  logic [TILE_ADDR_WIDTH-1:0] rd_addr,
    output logic [TILE_WIDTH-1:0]      rd_data
);

    // one tile per entry
    // lane k of a tile sits at bits [16k+15:16k]
    logic [TILE_WIDTH-1:0] mem [TILE_COUNT_MAX];

    // write port, fed from the loader register stage
    always_ff @(posedge clk) begin
        if (wr.wr_en) begin
            mem[wr.wr_addr] <= wr.wr_data;
        end
    end

    // registered read, one cycle latency
    // rd_data holds its value while rd_en is low, the engine
    // relies on that to keep a prefetched tile across a handshake
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    // note that a read and a write to the same entry in one
    // cycle return the old tile, the layer flow never does this
    // since reads only run in the pool layer

endmodule

/* rtl/fm_tile_loader.sv */
`timescale 1ns/1ps

module fm_tile_loader import cnn_pkg::*; (
    input  logic                       clk,
    input  logic                       arst_n,
    input  layer_type_e                layer_type,
    input  logic                       fm_write,            // one-cycle write strobe
    input  logic [TILE_ADDR_WIDTH-1:0] write_fm_data_addr,
    input  logic [TILE_WIDTH-1:0]      init_fm_data,
    input  logic                       init_fm_data_done,   // level from the host
    fm_write_if.loader                 wr,
    output logic                       init_fm_ram_ready
);

    loader_state_e state;
    loader_state_e state_nxt;
    logic          wr_take;   // write seen during the init layer

    assign wr_take = fm_write && (layer_type == LAYER_INIT);

    // register the write, buffer stores it on the following edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr.wr_en <= 1'b0;
        end else begin
            wr.wr_en <= wr_take;   // 5-bit address always inside the 32 entries
        end
    end

    always_ff @(posedge clk) begin
        if (wr_take) begin
            wr.wr_addr <= write_fm_data_addr;
            wr.wr_data <= init_fm_data;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            LD_IDLE:  if (wr_take) state_nxt = LD_FILL;
            // done with a write in the same cycle waits one more cycle
            LD_FILL:  if (init_fm_data_done && !wr_take) state_nxt = LD_READY;
            LD_READY: if (wr_take) state_nxt = LD_FILL;   // new map starts
            default:  state_nxt = LD_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= LD_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign init_fm_ram_ready = (state == LD_READY);
    assign wr.fill_done      = init_fm_ram_ready;   // same flag toward the engine

endmodule

/* rtl/fm_write_if.sv */
`timescale 1ns/1ps

// write path from the tile loader into the tile buffer
interface fm_write_if import cnn_pkg::*; ();

    logic                       wr_en;      // one-cycle write strobe
    logic [TILE_ADDR_WIDTH-1:0] wr_addr;    // tile address
    logic [TILE_WIDTH-1:0]      wr_data;    // nine float16 lanes
    logic                       fill_done;  // map loaded, level

    // loader owns every signal
    modport loader (
        output wr_en,
        output wr_addr,
        output wr_data,
        output fill_done
    );

    // buffer only sees the write port
    modport ram (
        input wr_en,
        input wr_addr,
        input wr_data
    );

endinterface

/* rtl/cnn_pkg.sv */
package cnn_pkg;

    // float16 element and 3x3 tile geometry
    localparam int DATA_WIDTH = 16;                          // one half-precision value
    localparam int PARA_X = 3;                               // tile width in elements
    localparam int PARA_Y = 3;                               // tile height in elements
    localparam int TILE_WIDTH = PARA_X * PARA_Y * DATA_WIDTH; // 144 bits, lane 0 at lsb

    // tile buffer sizing
    localparam int TILE_ADDR_WIDTH = 5;
    localparam int TILE_COUNT_MAX = 32;                      // entries in the tile buffer

    // layer geometry inputs
    localparam int FM_SIZE_WIDTH = 4;                        // fm_size is 3, 6, 9 or 12
    localparam int DEPTH_WIDTH = 2;                          // fm_depth is 1 or 2

    // layer opcode, same encoding as the layer_type input
    typedef enum logic [1:0] {
        LAYER_INIT = 2'd0,   // load feature map tiles
        LAYER_CONV = 2'd1,
        LAYER_POOL = 2'd2,
        LAYER_FC   = 2'd3
    } layer_type_e;

    typedef enum logic [1:0] {
        LD_IDLE,     // nothing written yet
        LD_FILL,     // writes arriving
        LD_READY     // done seen, map complete
    } loader_state_e;

    typedef enum logic [2:0] {
        PL_IDLE,     // wait for pool layer and a full map
        PL_FETCH,    // issue read of the next tile
        PL_REDUCE,   // rd_data valid, register its max
        PL_REQ,      // out_req high, wait ack
        PL_RELEASE,  // out_req low, wait ack low
        PL_DONE      // all tiles out, layer_ready high
    } pool_state_e;

endpackage
